// File: sim/sram_cases.txt
# columns: op addr be wdata rdata, all hex; op is W write, R read or I idle
# rdata is the value expected on rdata_o one cycle after the operation
# full-word writes and read-back
W 010 1f 5a12345678 0000000000
R 010 00 0000000000 5a12345678
W 3ff 1f 7fffffffff 5a12345678
R 3ff 00 0000000000 7fffffffff
W 7ff 1f 0123456789 7fffffffff
R 7ff 00 0000000000 0123456789
# partial byte enables, the top enable covers bits 38:32
W 020 1f 1122334455 0123456789
W 020 05 66aabbccdd 0123456789
R 020 00 0000000000 1122bb44dd
W 020 10 7f00000000 1122bb44dd
R 020 00 0000000000 7f22bb44dd
W 020 0a 00a5a5a5a5 7f22bb44dd
R 020 00 0000000000 7fa5bba5dd
W 020 00 3fffffffff 7fa5bba5dd
R 020 00 0000000000 7fa5bba5dd
# eight neighbours sharing macro rows in both slices
W 100 1f 4011111111 7fa5bba5dd
W 101 1f 4122222222 7fa5bba5dd
W 102 1f 4233333333 7fa5bba5dd
W 103 1f 4344444444 7fa5bba5dd
W 104 1f 4455555555 7fa5bba5dd
W 105 1f 4566666666 7fa5bba5dd
W 106 1f 4677777777 7fa5bba5dd
W 107 1f 4788888888 7fa5bba5dd
R 103 00 0000000000 4344444444
R 100 00 0000000000 4011111111
R 107 00 0000000000 4788888888
R 101 00 0000000000 4122222222
R 106 00 0000000000 4677777777
R 102 00 0000000000 4233333333
R 105 00 0000000000 4566666666
R 104 00 0000000000 4455555555
# read data holds through writes and idle cycles
W 101 1f 0000000000 4455555555
I 000 00 0000000000 4455555555
I 000 00 0000000000 4455555555
W 104 1f 0abcdef012 4455555555
I 000 00 0000000000 4455555555
R 104 00 0000000000 0abcdef012
R 101 00 0000000000 0000000000
R 105 00 0000000000 4566666666

// File: flist.f
rtl/sram_pkg.sv
rtl/sram_req_decode.sv
rtl/sram_macro.sv
rtl/sram_read_select.sv
rtl/sram_slice.sv
rtl/sram_interleaved_top.sv
sim/tb_sram_interleaved.sv

// File: sim/tb_sram_interleaved.sv
// testbench for the interleaved sram, replays the case file and checks a random fill
`timescale 1ns/1ps

module tb_sram_interleaved;

  localparam int unsigned NumWords     = 2048;
  localparam int unsigned DataWidth    = 39;
  localparam int unsigned AddrWidth    = $clog2(NumWords);
  localparam int unsigned BeWidth      = (DataWidth + 7) / 8;
  localparam int unsigned NumRandom    = 64;    // addresses in the random phase
  localparam int unsigned ResetTimeout = 64;    // cycles
  localparam int unsigned MaxCaseLines = 1000;

  typedef logic [DataWidth-1:0] word_t;

  // one line of the case file
  typedef struct packed {
    logic [7:0]           op;     // W, R or I
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    word_t                wdata;
    word_t                rdata;  // rdata_o expected after the operation
  } case_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  word_t                wdata;
  logic [BeWidth-1:0]   be;
  word_t                rdata;

  word_t       ref_mem [NumWords];  // reference model of the logical array
  word_t       last_read;           // reference value of the most recent read
  int          seed;
  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;

  sram_interleaved_top #(
    .NumWords  ( NumWords  ),
    .DataWidth ( DataWidth )
  ) sram_interleaved_top_i (
    .clk_i   ( clk   ),
    .rst_ni  ( rst_n ),
    .req_i   ( req   ),
    .we_i    ( we    ),
    .addr_i  ( addr  ),
    .wdata_i ( wdata ),
    .be_i    ( be    ),
    .rdata_o ( rdata )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t ns", name, actual, expected, $time);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before,
                             input int unsigned checks_before);
    n_tests++;
    $display("test %-12s %0d checks, %0d errors", name, n_checks - checks_before,
             n_errors - errors_before);
  endtask

  // masked write rule, byte i covers bits 8*i and up, the top byte only 7 bits
  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input logic [BeWidth-1:0] b);
    word_t result;
    result = old_word;
    for (int i = 0; i < DataWidth; i++) begin
      if (b[i/8]) begin
        result[i] = new_word[i];
      end
    end
    return result;
  endfunction

  function automatic word_t random_word();
    int lo;
    int hi;
    lo = $random(seed);
    hi = $random(seed);
    return {hi[DataWidth-33:0], lo};
  endfunction

  task automatic wait_reset(output logic ok);
    int unsigned cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < ResetTimeout) begin
      @(negedge clk);
      cycles++;
    end
    ok = (rst_n === 1'b1);
  endtask

  // drive at a falling edge, come back one cycle later with rdata_o settled
  task automatic access(input logic do_req, input logic do_we, input logic [AddrWidth-1:0] a,
                        input logic [BeWidth-1:0] b, input word_t d);
    req   = do_req;
    we    = do_we;
    addr  = a;
    be    = b;
    wdata = d;
    @(posedge clk);
    @(negedge clk);
    req = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] a, input logic [BeWidth-1:0] b,
                            input word_t d);
    access(1'b1, 1'b1, a, b, d);
    ref_mem[a] = merge_bytes(ref_mem[a], d, b);
  endtask

  task automatic run_case(input case_t c);
    case (c.op)
      "W": write_word(c.addr, c.be, c.wdata);
      "R": begin
        access(1'b1, 1'b0, c.addr, '0, '0);
        last_read = ref_mem[c.addr];
        check_value("ref_mem", ref_mem[c.addr], c.rdata);  // catches a bad case line
      end
      "I": access(1'b0, 1'b0, c.addr, '0, '0);
      default: begin
        $display("unknown operation code 0x%h in the case file", c.op);
        n_errors++;
      end
    endcase
    check_value("rdata_o", rdata, c.rdata);
  endtask

  task automatic test_reset_value();
    int unsigned errors_before;
    int unsigned checks_before;
    errors_before = n_errors;
    checks_before = n_checks;
    check_value("rdata_o", rdata, '0);  // no read issued yet
    finish_test("reset_value", errors_before, checks_before);
  endtask

  task automatic test_case_file();
    int          fd;
    int          n_fields;
    int unsigned line_no;
    string       line;
    case_t       c;
    logic [7:0]           op;
    logic [AddrWidth-1:0] a;
    logic [BeWidth-1:0]   b;
    word_t                d;
    word_t                e;
    int unsigned errors_before;
    int unsigned checks_before;
    errors_before = n_errors;
    checks_before = n_checks;
    fd = $fopen("sim/sram_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file sim/sram_cases.txt");
      n_errors++;
    end else begin
      line_no = 0;
      while (!$feof(fd) && line_no < MaxCaseLines) begin
        line_no++;
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n_fields = $sscanf(line, "%c %h %h %h %h", op, a, b, d, e);
          if (n_fields != 5) begin
            $display("case file line %0d could not be parsed", line_no);
            n_errors++;
          end else begin
            c.op    = op;
            c.addr  = a;
            c.be    = b;
            c.wdata = d;
            c.rdata = e;
            run_case(c);
          end
        end
      end
      $fclose(fd);
    end
    finish_test("case_file", errors_before, checks_before);
  endtask

  task automatic test_random_fill();
    logic [AddrWidth-1:0] addr_list [NumRandom];
    logic [BeWidth-1:0]   b;
    int unsigned          idx;
    int unsigned          errors_before;
    int unsigned          checks_before;
    errors_before = n_errors;
    checks_before = n_checks;
    // full words first, so every byte of a picked address is defined
    for (int i = 0; i < NumRandom; i++) begin
      addr_list[i] = AddrWidth'($random(seed));
      write_word(addr_list[i], '1, random_word());
    end
    for (int i = 0; i < NumRandom; i++) begin
      idx = $unsigned($random(seed)) % NumRandom;
      b   = BeWidth'($random(seed));
      write_word(addr_list[idx], b, random_word());
      check_value("rdata_o", rdata, last_read);  // writes leave the read data alone
    end
    for (int i = NumRandom - 1; i >= 0; i--) begin
      access(1'b1, 1'b0, addr_list[i], '0, '0);
      last_read = ref_mem[addr_list[i]];
      check_value("rdata_o", rdata, ref_mem[addr_list[i]]);
    end
    finish_test("random_fill", errors_before, checks_before);
  endtask

  initial begin : main
    logic reset_ok;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    last_read = '0;
    seed      = 13041;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;
    wait_reset(reset_ok);
    if (reset_ok) begin
      test_reset_value();
      test_case_file();
      test_random_fill();
    end else begin
      $display("reset was not released within %0d cycles", ResetTimeout);
      n_errors++;
    end
    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: rtl/sram_interleaved_top.sv
// sram interleaved top, splits the logical word over a 2:1 main slice and an 8:1 side slice
`timescale 1ns/1ps

module sram_interleaved_top
  import sram_pkg::*;
#(
  parameter int unsigned NumWords  = 2048,
  parameter int unsigned DataWidth = 39,
  // derived, not meant to be overridden
  parameter int unsigned AddrWidth = (NumWords > 1) ? $clog2(NumWords) : 1,
  parameter int unsigned BeWidth   = (DataWidth + ByteWidth - 1) / ByteWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]   be_i,
  output logic [DataWidth-1:0] rdata_o
);

  // low 32 bits, two words per macro row
  sram_slice #(
    .NumWords   ( NumWords       ),
    .SliceWidth ( MainWidth      ),
    .Interleave ( MainInterleave )
  ) i_main_slice (
    .clk_i   ( clk_i                          ),
    .rst_ni  ( rst_ni                         ),
    .req_i   ( req_i                          ),
    .we_i    ( we_i                           ),
    .addr_i  ( addr_i                         ),
    .wdata_i ( wdata_i[MainWidth-1:0]         ),
    .be_i    ( be_i[MainWidth/ByteWidth-1:0]  ),
    .rdata_o ( rdata_o[MainWidth-1:0]         )
  );

  // bits above 32, eight words per row, covered by the top byte enable
  if (DataWidth > MainWidth) begin : gen_side_slice
    sram_slice #(
      .NumWords   ( NumWords              ),
      .SliceWidth ( DataWidth - MainWidth ),
      .Interleave ( SideInterleave        )
    ) i_side_slice (
      .clk_i   ( clk_i                            ),
      .rst_ni  ( rst_ni                           ),
      .req_i   ( req_i                            ),
      .we_i    ( we_i                             ),
      .addr_i  ( addr_i                           ),
      .wdata_i ( wdata_i[DataWidth-1:MainWidth]   ),
      .be_i    ( be_i[BeWidth-1]                  ),
      .rdata_o ( rdata_o[DataWidth-1:MainWidth]   )
    );
  end

endmodule

// File: rtl/sram_slice.sv
// sram slice, one interleaved storage slice built from decode, macro and read select
`timescale 1ns/1ps

module sram_slice
  import sram_pkg::*;
#(
  parameter int unsigned NumWords   = 2048,
  parameter int unsigned SliceWidth = 32,
  parameter int unsigned Interleave = 2,
  // derived, not meant to be overridden
  parameter int unsigned AddrWidth  = (NumWords > 1) ? $clog2(NumWords) : 1,
  parameter int unsigned BeWidth    = (SliceWidth + ByteWidth - 1) / ByteWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [AddrWidth-1:0]  addr_i,
  input  logic [SliceWidth-1:0] wdata_i,
  input  logic [BeWidth-1:0]    be_i,
  output logic [SliceWidth-1:0] rdata_o
);

  localparam int unsigned LaneWidth = (Interleave > 1) ? $clog2(Interleave) : 1;
  localparam int unsigned RowWidth  = AddrWidth - LaneWidth;
  localparam int unsigned NumRows   = NumWords / Interleave;  // macro depth

  typedef logic [RowWidth-1:0] row_t;

  logic [SliceWidth-1:0] bm;
  logic [LaneWidth-1:0]  lane;
  row_t                  row;
  macro_req_t            macro_req;
  macro_data_t           dout;

  // byte enables to bit mask
  always_comb begin
    for (int b = 0; b < SliceWidth; b++) begin
      bm[b] = be_i[b/ByteWidth];
    end
  end

  assign lane = addr_i[LaneWidth-1:0];          // low bits pick the lane
  assign row  = addr_i[AddrWidth-1:LaneWidth];  // the rest pick the macro row

  sram_req_decode #(
    .SliceWidth ( SliceWidth ),
    .Interleave ( Interleave )
  ) i_req_decode (
    .req_i       ( req_i     ),
    .we_i        ( we_i      ),
    .lane_i      ( lane      ),
    .wdata_i     ( wdata_i   ),
    .bm_i        ( bm        ),
    .macro_req_o ( macro_req )
  );

  sram_macro #(
    .NumRows ( NumRows ),
    .row_t   ( row_t   )
  ) i_macro (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .row_i       ( row       ),
    .macro_req_i ( macro_req ),
    .dout_o      ( dout      )
  );

  sram_read_select #(
    .SliceWidth ( SliceWidth ),
    .Interleave ( Interleave )
  ) i_read_select (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .we_i    ( we_i    ),
    .lane_i  ( lane    ),
    .dout_i  ( dout    ),
    .rdata_o ( rdata_o )
  );

endmodule

// File: rtl/sram_read_select.sv
// sram read select, registers the read lane and picks its bits from the macro output
`timescale 1ns/1ps

module sram_read_select
  import sram_pkg::*;
#(
  parameter int unsigned SliceWidth = 32,
  parameter int unsigned Interleave = 2,
  // derived, not meant to be overridden
  parameter int unsigned LaneWidth  = (Interleave > 1) ? $clog2(Interleave) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [LaneWidth-1:0]  lane_i,
  input  macro_data_t           dout_i,
  output logic [SliceWidth-1:0] rdata_o
);

  logic [LaneWidth-1:0] lane_q;

  // lane of the last read, the macro data shows up one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_q <= '0;
    end else if (req_i && !we_i) begin
      lane_q <= lane_i;
    end
  end

  always_comb begin
    for (int i = 0; i < SliceWidth; i++) begin
      rdata_o[i] = dout_i[i*Interleave+int'(lane_q)];  // neighbour mux
    end
  end

endmodule

// File: rtl/sram_macro.sv
// sram macro, behavioral 64-bit single-port array with bit mask and registered read data
`timescale 1ns/1ps

module sram_macro
  import sram_pkg::*;
#(
  parameter int unsigned NumRows = 1024,
  parameter type         row_t   = logic [9:0]
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  row_t        row_i,
  input  macro_req_t  macro_req_i,
  output macro_data_t dout_o
);

  macro_data_t mem_q [NumRows];

  logic wr_en;
  logic rd_en;

  assign wr_en = macro_req_i.men & macro_req_i.wen;
  assign rd_en = macro_req_i.men & ~macro_req_i.wen;

  // masked write, untouched bits keep their old value
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[row_i] <= (mem_q[row_i] & ~macro_req_i.bm) |
                      (macro_req_i.din & macro_req_i.bm);
    end
  end

  // read port, output held between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dout_o <= '0;
    end else if (rd_en) begin
      dout_o <= mem_q[row_i];
    end
  end

endmodule

// File: rtl/sram_req_decode.sv
// sram request decode, spreads slice write data and bit mask over the interleaved macro lanes
`timescale 1ns/1ps

module sram_req_decode
  import sram_pkg::*;
#(
  parameter int unsigned SliceWidth = 32,
  parameter int unsigned Interleave = 2,
  // derived, not meant to be overridden
  parameter int unsigned LaneWidth  = (Interleave > 1) ? $clog2(Interleave) : 1
) (
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [LaneWidth-1:0]  lane_i,
  input  logic [SliceWidth-1:0] wdata_i,
  input  logic [SliceWidth-1:0] bm_i,
  output macro_req_t            macro_req_o
);

  macro_data_t din;
  macro_data_t bm;

  // neighbouring macro bits hold the same logical bit of different words,
  // so the lane mux at the output stays local
  always_comb begin
    din = '0;  // unused upper macro bits stay quiet
    bm  = '0;
    for (int i = 0; i < SliceWidth; i++) begin
      for (int l = 0; l < Interleave; l++) begin
        din[i*Interleave+l] = wdata_i[i];  // every lane sees the data
        bm[i*Interleave+l]  = bm_i[i] & (lane_i == LaneWidth'(l));
      end
    end
  end

  always_comb begin
    macro_req_o.men = req_i;
    macro_req_o.wen = we_i;
    macro_req_o.din = din;
    macro_req_o.bm  = bm;
  end

endmodule

// File: rtl/sram_pkg.sv
// sram package with the 64-bit macro geometry and the macro request struct
package sram_pkg;

  // physical macro geometry
  localparam int unsigned MacroWidth = 64;
  localparam int unsigned ByteWidth  = 8;   // bits per byte enable

  // logical word split
  localparam int unsigned MainWidth      = 32;  // low bits in the main slice
  localparam int unsigned MainInterleave = 2;   // 2:1, addr bit 0 picks the lane
  localparam int unsigned SideInterleave = 8;   // 8:1, addr bits 2:0 pick the lane

  // one macro-wide vector, used for write data, bit mask and read data
  typedef logic [MacroWidth-1:0] macro_data_t;

  // one access to a physical macro
  typedef struct packed {
    logic        men;  // access enable
    logic        wen;  // 1 write, 0 read
    macro_data_t din;  // write data, already spread over the lanes
    macro_data_t bm;   // per-bit write mask
  } macro_req_t;

endpackage
